// File: build.f
rtl/sfm_fixed_pkg.sv
rtl/sfm_acc_pkg.sv
rtl/sfm_dispatcher.sv
rtl/sfm_lane_mac.sv
rtl/sfm_lane_reducer.sv
rtl/sfm_reciprocal.sv
rtl/sfm_accumulator_top.sv
tests/tb_sfm_accumulator.sv

// File: rtl/sfm_acc_pkg.sv
package sfm_acc_pkg;

    import sfm_fixed_pkg::*;

    // interleaved partial sums
    localparam int unsigned N_LANES = 4;

    typedef logic [$clog2(N_LANES)-1:0] lane_idx_t;

    // one input item, last marks the packet end
    typedef struct packed {
        value_t addend;
        value_t factor;
        logic   last;
    } sfm_item_t;

    // denominator and its reciprocal
    typedef struct packed {
        sum_t sum;
        sum_t recip;
    } sfm_result_t;

endpackage

// File: rtl/sfm_accumulator_top.sv
`timescale 1ns/1ps

module sfm_accumulator_top
    import sfm_fixed_pkg::*;
    import sfm_acc_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        in_valid_i,
    input  sfm_item_t   item_i,
    output logic        in_ready_o,
    output logic        out_valid_o,
    input  logic        out_ready_i,
    output sfm_result_t result_o
);

    logic [N_LANES-1:0] lane_valid;
    logic [N_LANES-1:0] lane_ready;
    logic [N_LANES-1:0] lane_idle;
    sum_t [N_LANES-1:0] lane_sum;
    sfm_item_t          lane_item;
    logic               lane_clear;
    logic               packet_end;
    logic               drained;
    logic               recip_start;
    logic               recip_done;
    sum_t               total;
    sum_t               recip;

    sfm_dispatcher u_dispatcher (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .clear_i      (clear_i),
        .in_valid_i   (in_valid_i),
        .item_i       (item_i),
        .in_ready_o   (in_ready_o),
        .lane_ready_i (lane_ready),
        .lane_valid_o (lane_valid),
        .lane_item_o  (lane_item),
        .packet_end_o (packet_end),
        .drained_i    (drained)
    );

    for (genvar i = 0; i < N_LANES; i++) begin : gen_lanes
        sfm_lane_mac u_lane (
            .clk_i        (clk_i),
            .rst_ni       (rst_ni),
            .clear_i      (clear_i),
            .valid_i      (lane_valid[i]),
            .item_i       (lane_item),
            .ready_o      (lane_ready[i]),
            .lane_clear_i (lane_clear),
            .sum_o        (lane_sum[i]),
            .idle_o       (lane_idle[i])
        );
    end

    sfm_lane_reducer u_reducer (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .clear_i       (clear_i),
        .packet_end_i  (packet_end),
        .lane_sum_i    (lane_sum),
        .lane_idle_i   (lane_idle),
        .lane_clear_o  (lane_clear),
        .recip_start_o (recip_start),
        .total_o       (total),
        .recip_done_i  (recip_done),
        .recip_i       (recip),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .result_o      (result_o),
        .drained_o     (drained)
    );

    sfm_reciprocal u_reciprocal (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .start_i (recip_start),
        .den_i   (total),
        .done_o  (recip_done),
        .recip_o (recip)
    );

endmodule

// File: rtl/sfm_dispatcher.sv
`timescale 1ns/1ps

module sfm_dispatcher
    import sfm_acc_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 clear_i,
    input  logic                 in_valid_i,
    input  sfm_item_t            item_i,
    output logic                 in_ready_o,
    input  logic [N_LANES-1:0]   lane_ready_i,
    output logic [N_LANES-1:0]   lane_valid_o,
    output sfm_item_t            lane_item_o,
    output logic                 packet_end_o,
    input  logic                 drained_i
);

    lane_idx_t ptr_q;
    logic      accepting_q;
    logic      xfer;

    // only the pointed lane sees the item
    assign in_ready_o = accepting_q & lane_ready_i[ptr_q];
    assign xfer = in_valid_i & in_ready_o;
    assign packet_end_o = xfer & item_i.last;
    assign lane_item_o = item_i;

    always_comb begin
        lane_valid_o = '0;
        lane_valid_o[ptr_q] = accepting_q & in_valid_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q       <= '0;
            accepting_q <= 1'b1;
        end else if (clear_i) begin
            ptr_q       <= '0;
            accepting_q <= 1'b1;
        end else begin
            if (xfer) begin
                if (item_i.last || ptr_q == lane_idx_t'(N_LANES - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= ptr_q + 1'b1;
                end
            end
            // closed from the last item until the result is taken
            if (packet_end_o) begin
                accepting_q <= 1'b0;
            end else if (drained_i) begin
                accepting_q <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/sfm_fixed_pkg.sv
package sfm_fixed_pkg;

    // unsigned fixed point, 8 fraction bits everywhere
    localparam int unsigned FRAC_BITS = 8;

    // addend and factor are Q8.8
    localparam int unsigned VALUE_W = 16;

    // partial sums, total and reciprocal are Q16.8
    localparam int unsigned SUM_W = 24;

    typedef logic [VALUE_W-1:0] value_t;
    typedef logic [SUM_W-1:0]   sum_t;

    // 1.0 in Q8.8
    localparam value_t ONE = value_t'(1 << FRAC_BITS);

    // newton steps after the leading-one estimate
    localparam int unsigned N_INV_ITERS = 2;

    // returned for a zero denominator
    localparam sum_t INV_SAT = '1;

endpackage

// File: rtl/sfm_lane_mac.sv
`timescale 1ns/1ps

module sfm_lane_mac
    import sfm_fixed_pkg::*;
    import sfm_acc_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      clear_i,
    input  logic      valid_i,
    input  sfm_item_t item_i,
    output logic      ready_o,
    input  logic      lane_clear_i,
    output sum_t      sum_o,
    output logic      idle_o
);

    localparam int unsigned PROD_W = SUM_W + VALUE_W;

    logic              busy_q;
    sum_t              sum_q;
    logic [PROD_W-1:0] prod_q;
    value_t            addend_q;
    logic [PROD_W-1:0] acc_next;
    logic              take;

    assign ready_o = ~busy_q;
    assign idle_o = ~busy_q;
    assign sum_o = sum_q;
    assign take = valid_i & ~busy_q;

    // second stage, scaled old sum plus addend
    assign acc_next = (prod_q >> FRAC_BITS) + PROD_W'(addend_q);

    // first stage, full width product of old sum and factor
    always_ff @(posedge clk_i) begin
        if (take) begin
            prod_q   <= PROD_W'(sum_q) * PROD_W'(item_i.factor);
            addend_q <= item_i.addend;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            sum_q  <= '0;
        end else if (clear_i || lane_clear_i) begin
            busy_q <= 1'b0;
            sum_q  <= '0;
        end else begin
            busy_q <= take;
            if (busy_q) begin
                // truncated to the sum width
                sum_q <= acc_next[SUM_W-1:0];
            end
        end
    end

endmodule

// File: rtl/sfm_lane_reducer.sv
`timescale 1ns/1ps

module sfm_lane_reducer
    import sfm_fixed_pkg::*;
    import sfm_acc_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  logic                   packet_end_i,
    input  sum_t [N_LANES-1:0]     lane_sum_i,
    input  logic [N_LANES-1:0]     lane_idle_i,
    output logic                   lane_clear_o,
    output logic                   recip_start_o,
    output sum_t                   total_o,
    input  logic                   recip_done_i,
    input  sum_t                   recip_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output sfm_result_t            result_o,
    output logic                   drained_o
);

    typedef enum logic [1:0] {S_WAIT, S_SUM, S_INV, S_HOLD} red_state_t;

    red_state_t  state_q;
    lane_idx_t   idx_q;
    logic        pend_q;
    logic        start_q;
    sum_t        total_q;
    sfm_result_t result_q;
    logic        out_xfer;

    assign out_valid_o = (state_q == S_HOLD);
    assign out_xfer = out_valid_o & out_ready_i;
    assign lane_clear_o = out_xfer;
    assign drained_o = out_xfer;
    assign recip_start_o = start_q;
    assign total_o = total_q;
    assign result_o = result_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= S_WAIT;
            idx_q   <= '0;
            pend_q  <= 1'b0;
            start_q <= 1'b0;
        end else if (clear_i) begin
            state_q <= S_WAIT;
            idx_q   <= '0;
            pend_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (packet_end_i) begin
                pend_q <= 1'b1;
            end
            case (state_q)
                S_WAIT: begin
                    // last item must have left every lane
                    if (pend_q && (&lane_idle_i)) begin
                        state_q <= S_SUM;
                        idx_q   <= '0;
                        pend_q  <= 1'b0;
                    end
                end
                S_SUM: begin
                    idx_q <= idx_q + 1'b1;
                    if (idx_q == lane_idx_t'(N_LANES - 1)) begin
                        state_q <= S_INV;
                        start_q <= 1'b1;
                    end
                end
                S_INV: begin
                    if (recip_done_i) begin
                        state_q <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    if (out_ready_i) begin
                        state_q <= S_WAIT;
                    end
                end
                default: state_q <= S_WAIT;
            endcase
        end
    end

    // one lane added per cycle
    always_ff @(posedge clk_i) begin
        if (state_q == S_WAIT) begin
            total_q <= '0;
        end else if (state_q == S_SUM) begin
            total_q <= total_q + lane_sum_i[idx_q];
        end
        if (state_q == S_INV && recip_done_i) begin
            result_q.sum   <= total_q;
            result_q.recip <= recip_i;
        end
    end

endmodule

// File: rtl/sfm_reciprocal.sv
`timescale 1ns/1ps

module sfm_reciprocal
    import sfm_fixed_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic clear_i,
    input  logic start_i,
    input  sum_t den_i,
    output logic done_o,
    output sum_t recip_o
);

    typedef enum logic [1:0] {R_IDLE, R_T, R_X} rcp_state_t;

    rcp_state_t                           state_q;
    logic [$clog2(N_INV_ITERS + 1)-1:0]   iter_q;
    logic                                 done_q;
    sum_t                                 den_q;
    sum_t                                 x_q;
    sum_t                                 t_q;
    sum_t                                 x_init;
    sum_t                                 t_next;
    sum_t                                 x_next;
    sum_t                                 two_one;
    logic [2*SUM_W-1:0]                   prod_t;
    logic [2*SUM_W-1:0]                   prod_x;

    assign done_o = done_q;
    assign recip_o = x_q;
    assign two_one = sum_t'(ONE) << 1;

    // start value from the leading one of the denominator
    always_comb begin
        int lead;
        int expo;
        lead = 0;
        for (int i = 0; i < SUM_W; i++) begin
            if (den_i[i]) begin
                lead = i;
            end
        end
        expo = (lead >= 2 * FRAC_BITS) ? 0 : 2 * FRAC_BITS - lead;
        if (expo > SUM_W - 1) begin
            expo = SUM_W - 1;
        end
        x_init = sum_t'(1) << expo;
    end

    // t = den * x, clamped at 2.0
    assign prod_t = (2*SUM_W)'(den_q) * (2*SUM_W)'(x_q);
    always_comb begin
        logic [2*SUM_W-1:0] shifted;
        shifted = prod_t >> FRAC_BITS;
        t_next = shifted[SUM_W-1:0];
        if (t_next > two_one) begin
            t_next = two_one;
        end
    end

    // x = x * (2 - t)
    assign prod_x = (2*SUM_W)'(x_q) * (2*SUM_W)'(two_one - t_q);
    always_comb begin
        logic [2*SUM_W-1:0] shifted;
        shifted = prod_x >> FRAC_BITS;
        x_next = shifted[SUM_W-1:0];
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            den_q <= den_i;
            x_q   <= (den_i == '0) ? INV_SAT : x_init;
        end else if (state_q == R_T) begin
            t_q <= t_next;
        end else if (state_q == R_X) begin
            x_q <= x_next;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= R_IDLE;
            iter_q  <= '0;
            done_q  <= 1'b0;
        end else if (clear_i) begin
            state_q <= R_IDLE;
            iter_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                R_IDLE: begin
                    iter_q <= '0;
                    if (start_i) begin
                        // zero total finishes at once
                        if (den_i == '0) begin
                            done_q <= 1'b1;
                        end else begin
                            state_q <= R_T;
                        end
                    end
                end
                R_T: state_q <= R_X;
                R_X: begin
                    iter_q <= iter_q + 1'b1;
                    if (iter_q == N_INV_ITERS - 1) begin
                        state_q <= R_IDLE;
                        done_q  <= 1'b1;
                    end else begin
                        state_q <= R_T;
                    end
                end
                default: state_q <= R_IDLE;
            endcase
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the accumulator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module tb_sfm_accumulator \
    -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: tests/tb_sfm_accumulator.sv
`timescale 1ns/1ps

module tb_sfm_accumulator
    import sfm_fixed_pkg::*;
    import sfm_acc_pkg::*;
();

    localparam int TIMEOUT = 200;
    localparam int PROD_W = SUM_W + VALUE_W;

    // clr discards the packet after this item
    typedef struct packed {
        value_t     addend;
        value_t     factor;
        logic       last;
        logic [7:0] stall;
        logic       clr;
    } step_t;

    logic        clk_i;
    logic        rst_ni;
    logic        clear_i;
    logic        in_valid_i;
    sfm_item_t   item_i;
    logic        in_ready_o;
    logic        out_valid_o;
    logic        out_ready_i;
    sfm_result_t result_o;

    step_t  steps[$];
    sum_t   model_lane [N_LANES];
    int     model_ptr;
    int     errors;
    int     checks;
    logic   timed_out;
    integer seed;

    sfm_accumulator_top uut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .in_valid_i  (in_valid_i),
        .item_i      (item_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .result_o    (result_o)
    );

    always begin
        #50 clk_i = ~clk_i;
    end

    // old sum times factor back to Q16.8 plus addend
    function automatic sum_t lane_step(sum_t old, value_t addend, value_t factor);
        logic [PROD_W-1:0] prod;
        logic [PROD_W-1:0] acc;
        prod = PROD_W'(old) * PROD_W'(factor);
        acc = (prod >> FRAC_BITS) + PROD_W'(addend);
        return acc[SUM_W-1:0];
    endfunction

    function automatic sum_t expect_recip(sum_t total);
        logic [2*SUM_W-1:0] prod;
        sum_t x;
        sum_t t;
        sum_t two;
        int   lead;
        int   expo;
        if (total == '0) begin
            return INV_SAT;
        end
        two = sum_t'(ONE) << 1;
        lead = 0;
        for (int i = 0; i < int'(SUM_W); i++) begin
            if (total[i]) begin
                lead = i;
            end
        end
        // start at 2^(2F - p) with the exponent kept inside the word
        expo = 2 * int'(FRAC_BITS) - lead;
        if (expo < 0) begin
            expo = 0;
        end
        if (expo > int'(SUM_W) - 1) begin
            expo = int'(SUM_W) - 1;
        end
        x = sum_t'(1) << expo;
        for (int k = 0; k < int'(N_INV_ITERS); k++) begin
            prod = (2*SUM_W)'(total) * (2*SUM_W)'(x);
            t = sum_t'(prod >> FRAC_BITS);
            if (t > two) begin
                t = two;
            end
            prod = (2*SUM_W)'(x) * (2*SUM_W)'(two - t);
            x = sum_t'(prod >> FRAC_BITS);
        end
        return x;
    endfunction

    function automatic sum_t model_total();
        sum_t acc;
        acc = '0;
        for (int l = 0; l < int'(N_LANES); l++) begin
            acc = acc + model_lane[l];
        end
        return acc;
    endfunction

    task automatic model_reset();
        for (int l = 0; l < int'(N_LANES); l++) begin
            model_lane[l] = '0;
        end
        model_ptr = 0;
    endtask

    // items go round robin over the lanes
    task automatic model_item(value_t addend, value_t factor);
        model_lane[model_ptr] = lane_step(model_lane[model_ptr], addend, factor);
        model_ptr = (model_ptr + 1) % int'(N_LANES);
    endtask

    task automatic report_mismatch(string name, sum_t got, sum_t expected);
        $display("error at %0t: %s = %h, expected %h", $time, name, got, expected);
        errors++;
    endtask

    task automatic add_step(value_t addend, value_t factor, logic last, int stall, logic clr);
        step_t s;
        s.addend = addend;
        s.factor = factor;
        s.last = last;
        s.stall = 8'(stall);
        s.clr = clr;
        steps.push_back(s);
    endtask

    task automatic load_table();
        logic [31:0] r_a;
        logic [31:0] r_f;
        // all factors one and longer than the lane count
        add_step(16'h0100, ONE, 1'b0, 0, 1'b0);
        add_step(16'h0280, ONE, 1'b0, 0, 1'b0);
        add_step(16'h0040, ONE, 1'b0, 0, 1'b0);
        add_step(16'h1000, ONE, 1'b0, 0, 1'b0);
        add_step(16'h0300, ONE, 1'b0, 0, 1'b0);
        add_step(16'h0020, ONE, 1'b1, 0, 1'b0);
        // shorter than the lane count
        add_step(16'h0500, ONE, 1'b0, 0, 1'b0);
        add_step(16'h0a00, ONE, 1'b1, 0, 1'b0);
        // scaled folds held under back-pressure
        add_step(16'h0200, 16'h0080, 1'b0, 0, 1'b0);
        add_step(16'h0100, 16'h0180, 1'b0, 0, 1'b0);
        add_step(16'h0340, 16'h00c0, 1'b0, 0, 1'b0);
        add_step(16'h0080, 16'h0200, 1'b0, 0, 1'b0);
        add_step(16'h0400, 16'h0080, 1'b0, 0, 1'b0);
        add_step(16'h0120, 16'h0180, 1'b0, 0, 1'b0);
        add_step(16'h0010, 16'h0140, 1'b0, 0, 1'b0);
        add_step(16'h0a00, 16'h00c0, 1'b1, 6, 1'b0);
        // zero total
        add_step(16'h0000, 16'h0200, 1'b0, 0, 1'b0);
        add_step(16'h0000, 16'h0200, 1'b0, 0, 1'b0);
        add_step(16'h0000, 16'h0200, 1'b1, 0, 1'b0);
        // cut off by clear before a packet of its own
        add_step(16'h0400, ONE, 1'b0, 0, 1'b0);
        add_step(16'h0300, ONE, 1'b0, 0, 1'b1);
        for (int k = 0; k < 5; k++) begin
            add_step(16'h0100, 16'h0200, k == 4, 1, 1'b0);
        end
        // cleared while its result is still on the way
        add_step(16'h0700, ONE, 1'b0, 0, 1'b0);
        add_step(16'h0200, ONE, 1'b1, 0, 1'b1);
        // leading one above the fraction range
        add_step(16'hff00, ONE, 1'b0, 0, 1'b0);
        add_step(16'hff00, ONE, 1'b1, 0, 1'b0);
        for (int k = 0; k < 8; k++) begin
            r_a = $random(seed);
            r_f = $random(seed);
            add_step(value_t'(r_a[11:0]), value_t'(r_f[7:0]) + value_t'(16'h0080), k == 7, 2,
                     1'b0);
        end
    endtask

    task automatic send_item(step_t s);
        int waited;
        waited = 0;
        in_valid_i = 1'b1;
        item_i.addend = s.addend;
        item_i.factor = s.factor;
        item_i.last = s.last;
        while (!in_ready_o && waited < TIMEOUT) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (!in_ready_o) begin
            $display("timeout at %0t: the DUT never accepted an input item", $time);
            timed_out = 1'b1;
            errors++;
        end else begin
            @(posedge clk_i);
            #1;
        end
        in_valid_i = 1'b0;
    endtask

    task automatic collect_result(int stall, sum_t exp_sum, sum_t exp_recip);
        sfm_result_t held;
        int          waited;
        waited = 0;
        while (!out_valid_o && waited < TIMEOUT) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (!out_valid_o) begin
            $display("timeout at %0t: the DUT never raised out_valid_o", $time);
            timed_out = 1'b1;
            errors++;
        end else begin
            checks += 2;
            if (result_o.sum != exp_sum) begin
                report_mismatch("result_o.sum", result_o.sum, exp_sum);
            end
            if (result_o.recip != exp_recip) begin
                report_mismatch("result_o.recip", result_o.recip, exp_recip);
            end
            held = result_o;
            // result frozen and input closed while out_ready_i is low
            for (int c = 0; c < stall; c++) begin
                @(posedge clk_i);
                #1;
                checks += 4;
                if (result_o.sum != held.sum) begin
                    report_mismatch("result_o.sum", result_o.sum, held.sum);
                end
                if (result_o.recip != held.recip) begin
                    report_mismatch("result_o.recip", result_o.recip, held.recip);
                end
                if (!out_valid_o) begin
                    report_mismatch("out_valid_o", sum_t'(out_valid_o), sum_t'(1));
                end
                if (in_ready_o) begin
                    report_mismatch("in_ready_o", sum_t'(in_ready_o), sum_t'(0));
                end
            end
            out_ready_i = 1'b1;
            @(posedge clk_i);
            #1;
            out_ready_i = 1'b0;
            checks++;
            if (out_valid_o) begin
                report_mismatch("out_valid_o", sum_t'(out_valid_o), sum_t'(0));
            end
        end
    endtask

    task automatic finish_packet(int stall);
        sum_t exp_total;
        exp_total = model_total();
        collect_result(stall, exp_total, expect_recip(exp_total));
        model_reset();
    endtask

    task automatic discard_packet();
        clear_i = 1'b1;
        @(posedge clk_i);
        #1;
        clear_i = 1'b0;
        model_reset();
        for (int c = 0; c < 12; c++) begin
            @(posedge clk_i);
            #1;
            checks++;
            if (out_valid_o) begin
                report_mismatch("out_valid_o", sum_t'(out_valid_o), sum_t'(0));
            end
        end
    endtask

    initial begin
        clk_i = 1'b0;
        rst_ni = 1'b0;
        clear_i = 1'b0;
        in_valid_i = 1'b0;
        item_i = '0;
        out_ready_i = 1'b0;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        seed = 32'hfff5b901;
        model_reset();
        load_table();
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        checks += 2;
        if (out_valid_o) begin
            report_mismatch("out_valid_o", sum_t'(out_valid_o), sum_t'(0));
        end
        if (!in_ready_o) begin
            report_mismatch("in_ready_o", sum_t'(in_ready_o), sum_t'(1));
        end
        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            send_item(steps[i]);
            if (!timed_out) begin
                model_item(steps[i].addend, steps[i].factor);
                if (steps[i].clr) begin
                    discard_packet();
                end else if (steps[i].last) begin
                    finish_packet(int'(steps[i].stall));
                end
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
